/* src.f */
+incdir+src
src/gat_pkg.sv
src/wh_bram.sv
src/dmvm_dot.sv
src/dmvm.sv
src/gat_top.sv
dv/tb_gat_top.sv

/* dv/dmvm_cases.hex */
// per case: node count, then one row per node (elem[7]..elem[0] bytes, count nibble, flag nibble)
// then a (a_2 bytes, then a_1 bytes), expected coef[7]..coef[0], expected node count; 0 ends the list
// single source node
1
404040404040404011
00000000000000004040404040404040
0000000000000040
1
// eight nodes, every tree level overflows
8
7F7F7F7F7F7F7F7F81
7F7F7F7F7F7F7F7F80
404040404040404080
C0C0C0C0C0C0C0C080
7F807F807F807F8080
000000000000000080
7F7F7F7FC0C0C0C080
303030303030303080
40404040404040407F7F7F7F7F7F7F7F
6F5E7E7A3E5F7E7E
8
// negative source score, only node 2 survives the relu
3
404040404040404031
101010101010101030
7F7F7F7F7F7F7F7F30
2020202020202020C0C0C0C0C0C0C0C0
00000000003C0000
3
0

/* dv/tb_gat_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "gat_defines.svh"

module tb_gat_top;

  localparam int CLK_PERIOD      = 4;
  localparam int CASE_WORDS      = 25;
  localparam int MAX_FILE_CASES  = 8;
  localparam int NUM_RAND        = 12;
  localparam int RUN_TIMEOUT     = `GAT_MAX_NODES + 20;
  localparam int NUM_RUNS        = MAX_FILE_CASES + NUM_RAND + 1;
  // reset plus every row written once
  localparam int LOAD_CYCLES     = 8 + (MAX_FILE_CASES + NUM_RAND) * (`GAT_MAX_NODES + 2);
  localparam int WATCHDOG_CYCLES = NUM_RUNS * RUN_TIMEOUT + LOAD_CYCLES;

  logic                      clk;
  logic                      rst_n;
  logic                      wh_we;
  logic [`GAT_WH_ADDR_W-1:0] wh_waddr;
  gat_pkg::wh_row_t          wh_wdata;
  logic                      dmvm_valid;
  gat_pkg::a_vec_t           a_vec;
  logic                      dmvm_ready;
  gat_pkg::coef_vec_t        coef;
  gat_pkg::node_cnt_t        num_nodes;

  logic [127:0] case_mem [CASE_WORDS];
  int unsigned  case_base [MAX_FILE_CASES];
  int unsigned  file_cases;

  gat_pkg::wh_row_t          rows_buf [`GAT_MAX_NODES];
  logic [`GAT_WH_ADDR_W-1:0] wr_ptr;

  int test_num;
  int tests_failed;
  int test_errs;
  int total_errs;
  int seed_ret;

  gat_top u_gat_top (
    .clk            (clk),
    .rst_n          (rst_n),
    .wh_we_i        (wh_we),
    .wh_waddr_i     (wh_waddr),
    .wh_wdata_i     (wh_wdata),
    .dmvm_valid_i   (dmvm_valid),
    .a_i            (a_vec),
    .dmvm_ready_o   (dmvm_ready),
    .coef_o         (coef),
    .num_of_nodes_o (num_nodes)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Error: watchdog expired before all tests completed");
    $display("Simulation finished: FAIL");
    $finish;
  end

  // reference model, integer arithmetic on the Q1.7 rules
  function automatic int q17_mul(input int x, input int y);
    int p;
    p = (x * y) >>> 7;
    p = p & 255;
    if (p > 127) begin
      p = p - 256;
    end
    return p;
  endfunction

  function automatic int tree_add(input int x, input int y);
    int s;
    s = x + y;
    if (s > 127 || s < -127) begin
      s = s >>> 1;
    end
    return s;
  endfunction

  function automatic int ref_score(input gat_pkg::wh_row_t row, input gat_pkg::a_vec_t av);
    int lvl [`GAT_W_COLS];
    int w;
    int a_el;
    for (int k = 0; k < `GAT_W_COLS; k++) begin
      if (row.src_flag) begin
        a_el = $signed(av[k]);
      end else begin
        a_el = $signed(av[k + `GAT_W_COLS]);
      end
      lvl[k] = q17_mul($signed(row.elem[k]), a_el);
    end
    w = `GAT_W_COLS;
    while (w > 1) begin
      for (int k = 0; k < w / 2; k++) begin
        lvl[k] = tree_add(lvl[2*k], lvl[2*k+1]);
      end
      w = w / 2;
    end
    return lvl[0];
  endfunction

  // coef[i] from the rows held in rows_buf
  function automatic gat_pkg::coef_vec_t ref_coef(input int n, input gat_pkg::a_vec_t av);
    int sc [`GAT_MAX_NODES];
    int c;
    gat_pkg::coef_vec_t res;
    res = '0;
    for (int i = 0; i < n; i++) begin
      sc[i] = ref_score(rows_buf[i], av);
    end
    for (int i = 0; i < n; i++) begin
      c = tree_add(sc[0], sc[i]);
      if (c > 0) begin
        res[i] = c[7:0];
      end
    end
    return res;
  endfunction

  function automatic gat_pkg::wh_row_t to_row(input logic [127:0] w);
    gat_pkg::wh_row_t r;
    r.elem      = w[71:8];
    r.num_nodes = w[7:4];
    r.src_flag  = w[0];
    return r;
  endfunction

  task automatic check_coef(input gat_pkg::coef_vec_t expected, input gat_pkg::coef_vec_t actual);
    if (actual !== expected) begin
      $display("Fail coef_o: expected %h, got %h", expected, actual);
      test_errs++;
      total_errs++;
    end
  endtask

  task automatic check_nodes(input gat_pkg::node_cnt_t expected, input gat_pkg::node_cnt_t actual);
    if (actual !== expected) begin
      $display("Fail num_of_nodes_o: expected %h, got %h", expected, actual);
      test_errs++;
      total_errs++;
    end
  endtask

  task automatic begin_test();
    test_num++;
    test_errs = 0;
  endtask

  task automatic end_test(input string desc);
    if (test_errs == 0) begin
      $display("test %0d, %s: ok", test_num, desc);
    end else begin
      tests_failed++;
      $display("test %0d, %s: %0d error(s)", test_num, desc, test_errs);
    end
  endtask

  task automatic write_row(input gat_pkg::wh_row_t row);
    @(negedge clk);
    wh_we    = 1'b1;
    wh_waddr = wr_ptr;
    wh_wdata = row;
    wr_ptr   = wr_ptr + 1'b1;
  endtask

  task automatic stop_writes();
    @(negedge clk);
    wh_we = 1'b0;
  endtask

  // hold valid until the ready pulse, then drop it
  task automatic run_subgraph(input gat_pkg::a_vec_t av);
    int   waited;
    logic got;
    @(negedge clk);
    a_vec      = av;
    dmvm_valid = 1'b1;
    got        = 1'b0;
    waited     = 0;
    while (!got && waited < RUN_TIMEOUT) begin
      @(negedge clk);
      waited++;
      got = (dmvm_ready === 1'b1);
    end
    dmvm_valid = 1'b0;
    if (!got) begin
      $display("Error: no dmvm_ready_o pulse within %0d cycles of dmvm_valid_i", RUN_TIMEOUT);
      test_errs++;
      total_errs++;
    end
  endtask

  task automatic verify_reset_state();
    int high_seen;
    begin_test();
    high_seen = 0;
    check_nodes('0, num_nodes);
    check_coef('0, coef);
    repeat (10) begin
      @(negedge clk);
      if (dmvm_ready !== 1'b0) begin
        high_seen++;
      end
    end
    if (high_seen != 0) begin
      $display("Error: dmvm_ready_o was not low while dmvm_valid_i stayed low");
      test_errs++;
      total_errs++;
    end
    end_test("reset state");
  endtask

  task automatic parse_cases();
    int unsigned idx;
    int unsigned n;
    idx        = 0;
    file_cases = 0;
    while (idx < CASE_WORDS && file_cases < MAX_FILE_CASES) begin
      if (case_mem[idx] === '0) begin
        break;
      end
      n = case_mem[idx][3:0];
      if (n < 1 || n > `GAT_MAX_NODES || idx + n + 3 >= CASE_WORDS) begin
        $display("Error: case file holds an invalid node count at word %0d", idx);
        total_errs++;
        break;
      end
      case_base[file_cases] = idx;
      file_cases++;
      idx = idx + n + 4;
    end
    if (file_cases == 0) begin
      $display("Error: no cases could be read from the case file");
      total_errs++;
    end
  endtask

  // all file rows go in once, runs then walk through them back to back
  task automatic load_file_rows();
    int unsigned n;
    for (int c = 0; c < file_cases; c++) begin
      n = case_mem[case_base[c]][3:0];
      for (int r = 0; r < n; r++) begin
        write_row(to_row(case_mem[case_base[c] + 1 + r]));
      end
    end
    stop_writes();
  endtask

  task automatic run_file_case(input int c);
    int unsigned base;
    int unsigned n;
    begin_test();
    base = case_base[c];
    n    = case_mem[base][3:0];
    run_subgraph(case_mem[base + n + 1]);
    check_coef(case_mem[base + n + 2][63:0], coef);
    check_nodes(case_mem[base + n + 3][3:0], num_nodes);
    end_test($sformatf("file case %0d, %0d nodes", c, n));
  endtask

  task automatic run_random_case();
    int                 n;
    gat_pkg::wh_row_t   row;
    gat_pkg::a_vec_t    av;
    gat_pkg::coef_vec_t expected;
    begin_test();
    n = 1 + int'($urandom % `GAT_MAX_NODES);
    for (int r = 0; r < n; r++) begin
      row.elem      = {$urandom, $urandom};
      row.num_nodes = n[3:0];
      row.src_flag  = (r == 0);
      rows_buf[r]   = row;
      write_row(row);
    end
    stop_writes();
    av       = {$urandom, $urandom, $urandom, $urandom};
    expected = ref_coef(n, av);
    run_subgraph(av);
    check_coef(expected, coef);
    check_nodes(n[3:0], num_nodes);
    end_test($sformatf("random case, %0d nodes", n));
  endtask

  initial begin
    seed_ret     = $urandom(32'h7a26);
    rst_n        = 1'b0;
    wh_we        = 1'b0;
    wh_waddr     = '0;
    wh_wdata     = '0;
    dmvm_valid   = 1'b0;
    a_vec        = '0;
    wr_ptr       = '0;
    test_num     = 0;
    tests_failed = 0;
    test_errs    = 0;
    total_errs   = 0;
    $readmemh("dv/dmvm_cases.hex", case_mem);

    repeat (8) @(negedge clk);
    rst_n = 1'b1;

    verify_reset_state();
    parse_cases();
    load_file_rows();
    for (int c = 0; c < file_cases; c++) begin
      run_file_case(c);
    end
    for (int r = 0; r < NUM_RAND; r++) begin
      run_random_case();
    end

    $display("tests run: %0d, failed: %0d, errors: %0d", test_num, tests_failed, total_errs);
    if (tests_failed == 0 && total_errs == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src/gat_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "gat_defines.svh"

module gat_top (
  input  wire                       clk,
  input  wire                       rst_n,
  // host write port
  input  wire                       wh_we_i,
  input  wire [`GAT_WH_ADDR_W-1:0]  wh_waddr_i,
  input  wire gat_pkg::wh_row_t     wh_wdata_i,
  // run control
  input  wire                       dmvm_valid_i,
  input  wire gat_pkg::a_vec_t      a_i,
  output logic                      dmvm_ready_o,
  // results
  output gat_pkg::coef_vec_t        coef_o,
  output gat_pkg::node_cnt_t        num_of_nodes_o
);

  // engine read port
  logic [`GAT_WH_ADDR_W-1:0] rd_addr;
  gat_pkg::wh_row_t          rd_row;

  wh_bram u_wh_bram (
    .clk       (clk),
    .wr_en_i   (wh_we_i),
    .wr_addr_i (wh_waddr_i),
    .wr_row_i  (wh_wdata_i),
    .rd_addr_i (rd_addr),
    .rd_row_o  (rd_row)
  );

  dmvm u_dmvm (
    .clk            (clk),
    .rst_n          (rst_n),
    .dmvm_valid_i   (dmvm_valid_i),
    .dmvm_ready_o   (dmvm_ready_o),
    .a_i            (a_i),
    .rd_addr_o      (rd_addr),
    .rd_row_i       (rd_row),
    .coef_o         (coef_o),
    .num_of_nodes_o (num_of_nodes_o)
  );

endmodule

`default_nettype wire

/* src/dmvm.sv */
`timescale 1ns/1ps
`default_nettype none

`include "gat_defines.svh"

module dmvm (
  input  wire                       clk,
  input  wire                       rst_n,
  // run handshake
  input  wire                       dmvm_valid_i,
  output logic                      dmvm_ready_o,
  input  wire gat_pkg::a_vec_t      a_i,
  // row memory read port
  output logic [`GAT_WH_ADDR_W-1:0] rd_addr_o,
  input  wire gat_pkg::wh_row_t     rd_row_i,
  // results, held until the next ready
  output gat_pkg::coef_vec_t        coef_o,
  output gat_pkg::node_cnt_t        num_of_nodes_o
);

  localparam int IDX_W = $clog2(`GAT_MAX_NODES);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FIRST,
    ST_ISSUE,
    ST_WAIT
  } state_t;

  state_t state_q;

  // never cleared between runs, next run picks up where the last stopped
  logic [`GAT_WH_ADDR_W-1:0] rd_addr_q;

  gat_pkg::node_cnt_t n_lat_q;
  gat_pkg::node_cnt_t issued_q;
  gat_pkg::node_cnt_t sc_idx_q;

  logic row_valid_q;
  logic relu_go_q;
  logic ready_q;
  logic done_hold_q;

  logic start;
  logic issue;
  logic last_score;

  logic            score_valid;
  gat_pkg::score_t score;
  gat_pkg::score_t scores_q [`GAT_MAX_NODES];

  gat_pkg::coef_vec_t coef_d;
  gat_pkg::coef_vec_t coef_q;
  gat_pkg::node_cnt_t num_q;

  dmvm_dot u_dmvm_dot (
    .clk           (clk),
    .rst_n         (rst_n),
    .row_valid_i   (row_valid_q),
    .row_i         (rd_row_i),
    .a_i           (a_i),
    .score_valid_o (score_valid),
    .score_o       (score)
  );

  // valid must drop after a ready before another run starts
  assign start = dmvm_valid_i && !done_hold_q && (state_q == ST_IDLE);

  always_comb begin
    issue = 1'b0;
    case (state_q)
      ST_IDLE:  issue = start;
      ST_FIRST: issue = (rd_row_i.num_nodes > gat_pkg::node_cnt_t'(1));
      ST_ISSUE: issue = 1'b1;
      default:  issue = 1'b0;
    endcase
  end

  assign last_score = score_valid && (sc_idx_q + gat_pkg::node_cnt_t'(1) == n_lat_q);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q     <= ST_IDLE;
      rd_addr_q   <= '0;
      n_lat_q     <= '0;
      issued_q    <= '0;
      sc_idx_q    <= '0;
      row_valid_q <= 1'b0;
      relu_go_q   <= 1'b0;
      ready_q     <= 1'b0;
      done_hold_q <= 1'b0;
    end else begin
      row_valid_q <= issue;
      relu_go_q   <= last_score;
      ready_q     <= relu_go_q;

      if (issue) begin
        rd_addr_q <= rd_addr_q + 1'b1;
        issued_q  <= start ? gat_pkg::node_cnt_t'(1) : issued_q + 1'b1;
      end

      if (start) begin
        sc_idx_q <= '0;
      end else if (score_valid) begin
        sc_idx_q <= sc_idx_q + 1'b1;
      end

      if (last_score) begin
        done_hold_q <= 1'b1;
      end else if (!dmvm_valid_i) begin
        done_hold_q <= 1'b0;
      end

      case (state_q)
        ST_IDLE: begin
          if (start) begin
            state_q <= ST_FIRST;
          end
        end
        // first row is on the read port now
        ST_FIRST: begin
          n_lat_q <= rd_row_i.num_nodes;
          if (rd_row_i.num_nodes > gat_pkg::node_cnt_t'(2)) begin
            state_q <= ST_ISSUE;
          end else begin
            state_q <= ST_WAIT;
          end
        end
        ST_ISSUE: begin
          if (issued_q + gat_pkg::node_cnt_t'(1) == n_lat_q) begin
            state_q <= ST_WAIT;
          end
        end
        default: begin
          if (last_score) begin
            state_q <= ST_IDLE;
          end
        end
      endcase
    end
  end

  // scores by arrival order, source first
  always_ff @(posedge clk) begin
    if (score_valid && sc_idx_q < `GAT_MAX_NODES) begin
      scores_q[sc_idx_q[IDX_W-1:0]] <= score;
    end
  end

  // coef[i] = relu(score[0] + score[i]), zero past the node count
  always_comb begin
    gat_pkg::score_t pair_sum;
    coef_d = '0;
    for (int i = 0; i < `GAT_MAX_NODES; i++) begin
      pair_sum = gat_pkg::add_halve(scores_q[0], scores_q[i]);
      if (i < n_lat_q && !pair_sum[`GAT_DATA_W-1]) begin
        coef_d[i] = pair_sum;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      coef_q <= '0;
      num_q  <= '0;
    end else if (relu_go_q) begin
      coef_q <= coef_d;
      num_q  <= n_lat_q;
    end
  end

  assign rd_addr_o      = rd_addr_q;
  assign dmvm_ready_o   = ready_q;
  assign coef_o         = coef_q;
  assign num_of_nodes_o = num_q;

  a_ready_single: assert property (
    @(posedge clk) disable iff (!rst_n) dmvm_ready_o |=> !dmvm_ready_o
  );

  // count comes from the first row of the run
  a_count_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    (state_q == ST_FIRST) |=> (n_lat_q >= 1 && n_lat_q <= `GAT_MAX_NODES)
  );

endmodule

`default_nettype wire

/* src/dmvm_dot.sv */
`timescale 1ns/1ps
`default_nettype none

`include "gat_defines.svh"

module dmvm_dot (
  input  wire                    clk,
  input  wire                    rst_n,
  // one row per valid cycle
  input  wire                    row_valid_i,
  input  wire gat_pkg::wh_row_t  row_i,
  input  wire gat_pkg::a_vec_t   a_i,
  // score four cycles after its row
  output logic                   score_valid_o,
  output gat_pkg::score_t        score_o
);

  localparam int N1 = `GAT_W_COLS;
  localparam int N2 = N1 / 2;
  localparam int N3 = N2 / 2;

  gat_pkg::half_vec_t a_half;

  gat_pkg::score_t prod_q [N1];
  gat_pkg::score_t sum1_q [N2];
  gat_pkg::score_t sum2_q [N3];
  gat_pkg::score_t sum3_q;

  // one valid bit per stage
  logic [3:0] vld_q;

  // Q1.7 times Q1.7, back to Q1.7 by dropping 7 fraction bits
  function automatic gat_pkg::score_t scale_mul(
    input logic [`GAT_DATA_W-1:0] x,
    input logic [`GAT_DATA_W-1:0] y
  );
    logic signed [2*`GAT_DATA_W-1:0] p;
    p = $signed(x) * $signed(y);
    p = p >>> (`GAT_DATA_W - 1);
    return p[`GAT_DATA_W-1:0];
  endfunction

  // source row scored against a_1, neighbours against a_2
  always_comb begin
    if (row_i.src_flag) begin
      a_half = a_i[`GAT_W_COLS-1:0];
    end else begin
      a_half = a_i[`GAT_A_DEPTH-1:`GAT_W_COLS];
    end
  end

  // stage 1 products
  always_ff @(posedge clk) begin
    for (int k = 0; k < N1; k++) begin
      prod_q[k] <= scale_mul(row_i.elem[k], a_half[k]);
    end
  end

  // stages 2 to 4, pairwise adder tree
  always_ff @(posedge clk) begin
    for (int k = 0; k < N2; k++) begin
      sum1_q[k] <= gat_pkg::add_halve(prod_q[2*k], prod_q[2*k+1]);
    end
    for (int k = 0; k < N3; k++) begin
      sum2_q[k] <= gat_pkg::add_halve(sum1_q[2*k], sum1_q[2*k+1]);
    end
    sum3_q <= gat_pkg::add_halve(sum2_q[0], sum2_q[1]);
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[2:0], row_valid_i};
    end
  end

  assign score_valid_o = vld_q[3];
  assign score_o       = sum3_q;

  a_score_valid_known: assert property (
    @(posedge clk) disable iff (!rst_n) !$isunknown(score_valid_o)
  );

endmodule

`default_nettype wire

/* src/wh_bram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "gat_defines.svh"

module wh_bram (
  input  wire                          clk,
  // host side
  input  wire                          wr_en_i,
  input  wire [`GAT_WH_ADDR_W-1:0]     wr_addr_i,
  input  wire gat_pkg::wh_row_t        wr_row_i,
  // engine side
  input  wire [`GAT_WH_ADDR_W-1:0]     rd_addr_i,
  output gat_pkg::wh_row_t             rd_row_o
);

  localparam int unsigned DEPTH = 1 << `GAT_WH_ADDR_W;

  gat_pkg::wh_row_t mem [DEPTH];
  gat_pkg::wh_row_t rd_row_q;

  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem[wr_addr_i] <= wr_row_i;
    end
  end

  // registered read, old data on a same-address write
  always_ff @(posedge clk) begin
    rd_row_q <= mem[rd_addr_i];
  end

  assign rd_row_o = rd_row_q;

endmodule

`default_nettype wire

/* src/gat_pkg.sv */
`default_nettype none

`include "gat_defines.svh"

package gat_pkg;

  typedef logic [`GAT_NODE_W-1:0] node_cnt_t;

  typedef logic signed [`GAT_DATA_W-1:0] score_t;

  // elements are signed Q1.7, cast with $signed where used
  typedef logic [`GAT_A_DEPTH-1:0][`GAT_DATA_W-1:0] a_vec_t;
  typedef logic [`GAT_W_COLS-1:0][`GAT_DATA_W-1:0] half_vec_t;

  typedef logic [`GAT_MAX_NODES-1:0][`GAT_DATA_W-1:0] coef_vec_t;

  // source flag sits in bit 0, count just above it
  typedef struct packed {
    half_vec_t elem;
    node_cnt_t num_nodes;
    logic      src_flag;
  } wh_row_t;

  // 9-bit sum kept if it fits -127..127, otherwise halved
  function automatic score_t add_halve(input score_t x, input score_t y);
    logic signed [`GAT_DATA_W:0] sum;
    sum = {x[`GAT_DATA_W-1], x} + {y[`GAT_DATA_W-1], y};
    if (sum > 9'sd127 || sum < -9'sd127) begin
      return sum[`GAT_DATA_W:1];
    end
    return sum[`GAT_DATA_W-1:0];
  endfunction

endpackage

`default_nettype wire

/* src/gat_defines.svh */
`ifndef GAT_DEFINES_SVH
`define GAT_DEFINES_SVH

// element width, signed Q1.7
`define GAT_DATA_W 8

// attention vector a holds a_1 followed by a_2
`define GAT_A_DEPTH 16

// one WH row carries half of a's length
`define GAT_W_COLS 8

// largest subgraph, source node included
`define GAT_MAX_NODES 8

// node count field, wide enough for GAT_MAX_NODES
`define GAT_NODE_W 4

// 64 rows of WH memory
`define GAT_WH_ADDR_W 6

`endif
